//--- reg_bank.sv
// AXI4-Lite slave with eight 8-bit read/write registers, cleared by reset
// Every access answers OKAY; write address and data may arrive in either order
`timescale 1ns/1ps

module reg_bank (
    input  logic                 clk,
    input  logic                 rst_n,
    input  regs_pkg::reg_addr_t  awaddr,
    input  logic                 awvalid,
    output logic                 awready,
    input  regs_pkg::reg_data_t  wdata,
    input  logic                 wvalid,
    output logic                 wready,
    output regs_pkg::axi_resp_t  bresp,
    output logic                 bvalid,
    input  logic                 bready,
    input  regs_pkg::reg_addr_t  araddr,
    input  logic                 arvalid,
    output logic                 arready,
    output regs_pkg::reg_data_t  rdata,
    output regs_pkg::axi_resp_t  rresp,
    output logic                 rvalid,
    input  logic                 rready
);
    import regs_pkg::*;

    reg_data_t regs [REG_COUNT];
    reg_addr_t awaddr_q;
    reg_data_t wdata_q;
    logic      aw_held;
    logic      w_held;
    logic      aw_hs;
    logic      w_hs;
    logic      do_write;
    reg_addr_t wr_addr;
    reg_data_t wr_data;

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;

    // The write happens as soon as both halves are in, held or arriving now
    assign do_write = (aw_held || aw_hs) && (w_held || w_hs);
    assign wr_addr  = aw_held ? awaddr_q : awaddr;
    assign wr_data  = w_held ? wdata_q : wdata;

    // Write channels
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            bvalid  <= 1'b0;
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // Ready follows valid by one cycle and drops after the handshake
            awready <= awvalid && !awready && !aw_held && !bvalid;
            wready  <= wvalid && !wready && !w_held && !bvalid;
            if (do_write) begin
                regs[wr_addr] <= wr_data;
                aw_held       <= 1'b0;
                w_held        <= 1'b0;
                bvalid        <= 1'b1;
            end else begin
                if (aw_hs) begin
                    awaddr_q <= awaddr;
                    aw_held  <= 1'b1;
                end
                if (w_hs) begin
                    wdata_q <= wdata;
                    w_held  <= 1'b1;
                end
                if (bvalid && bready) begin
                    bvalid <= 1'b0;
                end
            end
        end
    end

    // Read channel, data is taken from the array when the address is accepted
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (arvalid && arready) begin
                rdata  <= regs[araddr];
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    assign bresp = RESP_OKAY;
    assign rresp = RESP_OKAY;

endmodule

//--- regs_pkg.sv
// Register map and AXI4-Lite field types for the control register bank
// Addresses are register indices with no byte offset, so no alignment applies
package regs_pkg;

    // Eight control registers sit behind the bridge
    localparam int REG_COUNT = 8;

    // Register index as carried on awaddr and araddr
    typedef logic [2:0] reg_addr_t;

    // Width of one control register and of the AXI data bus
    typedef logic [7:0] reg_data_t;

    // AXI4-Lite response field
    typedef logic [1:0] axi_resp_t;

    // The bank only ever answers OKAY
    localparam axi_resp_t RESP_OKAY = 2'b00;

endpackage

//--- run_sim.sh
#!/bin/sh
# Compiles the bridge and its testbench with Verilator, runs it and checks the log
# Run from the project root

rm -rf obj_dir sim.log

{ verilator --binary --timing --assert -Wno-fatal -j 0 \
      --top-module tb_spi_reg_bridge -f sim.f \
  && ./obj_dir/Vtb_spi_reg_bridge ; } > sim.log 2>&1 \
  || echo "TESTBENCH FAILED" >> sim.log

grep -q "TESTBENCH FAILED" sim.log && echo "Simulation failed, see sim.log" && exit 1
grep -q "TESTBENCH PASSED" sim.log && echo "Simulation passed" && exit 0
echo "No result found in sim.log" && exit 1

//--- sim.f
spi_pkg.sv
regs_pkg.sv
spi_slave.sv
spi_cmd_master.sv
reg_bank.sv
spi_reg_bridge.sv
spi_reg_bridge_checker.sv
tb_spi_reg_bridge.sv

//--- spi_cmd_master.sv
// SPI frame parser acting as AXI4-Lite master, one transaction outstanding at a time
// The master must leave enough clk cycles after a read command for the result to load
`timescale 1ns/1ps

module spi_cmd_master (
    input  logic                 clk,
    input  logic                 rst_n,
    input  spi_pkg::spi_byte_t   rx_byte,
    input  logic                 rx_valid,
    input  logic                 frame_active,
    output spi_pkg::spi_byte_t   tx_byte,
    output logic                 tx_load,
    output regs_pkg::reg_addr_t  awaddr,
    output logic                 awvalid,
    input  logic                 awready,
    output regs_pkg::reg_data_t  wdata,
    output logic                 wvalid,
    input  logic                 wready,
    input  regs_pkg::axi_resp_t  bresp,
    input  logic                 bvalid,
    output logic                 bready,
    output regs_pkg::reg_addr_t  araddr,
    output logic                 arvalid,
    input  logic                 arready,
    input  regs_pkg::reg_data_t  rdata,
    input  regs_pkg::axi_resp_t  rresp,
    input  logic                 rvalid,
    output logic                 rready
);
    import spi_pkg::*;
    import regs_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WAIT_DATA,
        ST_WRITE_REQ,
        ST_WRITE_RESP,
        ST_READ_REQ,
        ST_READ_RESP,
        ST_LOAD,
        ST_IGNORE
    } state_t;

    state_t    state;
    reg_addr_t addr_q;
    reg_data_t wdata_q;
    reg_data_t rdata_q;
    logic      aw_done;
    logic      w_done;
    logic      aw_hs;
    logic      w_hs;

    // Address and data may be taken by the bank on different cycles
    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // First byte of a frame is the command
                    if (rx_valid) begin
                        addr_q <= rx_byte[$bits(reg_addr_t)-1:0];
                        if (rx_byte[CMD_WRITE_BIT]) begin
                            state <= ST_WAIT_DATA;
                        end else begin
                            state <= ST_READ_REQ;
                        end
                    end
                end
                ST_WAIT_DATA: begin
                    if (rx_valid) begin
                        wdata_q <= rx_byte;
                        state   <= ST_WRITE_REQ;
                    end else if (!frame_active) begin
                        // Write aborted after the command byte, nothing is written
                        state <= ST_IDLE;
                    end
                end
                ST_WRITE_REQ: begin
                    if ((aw_done || aw_hs) && (w_done || w_hs)) begin
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                        state   <= ST_WRITE_RESP;
                    end else begin
                        aw_done <= aw_done || aw_hs;
                        w_done  <= w_done || w_hs;
                    end
                end
                ST_WRITE_RESP: begin
                    // Every response is OKAY, the write is done once bvalid arrives
                    if (bvalid) begin
                        state <= ST_IGNORE;
                    end
                end
                ST_READ_REQ: begin
                    if (arready) begin
                        state <= ST_READ_RESP;
                    end
                end
                ST_READ_RESP: begin
                    if (rvalid) begin
                        rdata_q <= rdata;
                        state   <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    state <= ST_IGNORE;
                end
                default: begin
                    // Trailing bytes are dropped until select goes away
                    if (!frame_active) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Payloads come straight from the latched command, stable while valid is up
    assign awaddr  = addr_q;
    assign araddr  = addr_q;
    assign wdata   = wdata_q;
    assign awvalid = (state == ST_WRITE_REQ) && !aw_done;
    assign wvalid  = (state == ST_WRITE_REQ) && !w_done;
    assign arvalid = (state == ST_READ_REQ);
    assign bready  = 1'b1;
    assign rready  = 1'b1;

    // Read result goes to the SPI slave for the next byte
    assign tx_byte = rdata_q;
    assign tx_load = (state == ST_LOAD);

endmodule

//--- spi_pkg.sv
// SPI framing definitions shared by the slave and the command parser
// Mode 0 only, and the filter length also sets the depth of the select history
package spi_pkg;

    // One byte as it travels over MOSI or MISO, MSB first
    typedef logic [7:0] spi_byte_t;

    // Bit position inside the byte currently on the wire
    typedef logic [2:0] bit_cnt_t;

    // Number of equal consecutive clk samples before a new SCK level counts
    // It is also the number of high select samples that end a frame
    localparam int SPI_FILTER_LEN = 8;

    // Command byte layout
    // Bit 7 set means a write, clear means a read
    localparam int CMD_WRITE_BIT = 7;

endpackage

//--- spi_reg_bridge.sv
// SPI mode 0 to register bridge, the SPI master drives all four pins
// MISO is low outside a frame and is not tri-stated here
`timescale 1ns/1ps

module spi_reg_bridge (
    input  logic clk,
    input  logic rst_n,
    input  logic spi_sck,
    input  logic spi_ss_n,
    input  logic spi_mosi,
    output logic spi_miso
);
    import spi_pkg::*;
    import regs_pkg::*;

    spi_byte_t rx_byte;
    spi_byte_t tx_byte;
    logic      rx_valid;
    logic      frame_active;
    logic      tx_load;

    // Internal AXI4-Lite link from the parser to the bank
    reg_addr_t awaddr;
    logic      awvalid;
    logic      awready;
    reg_data_t wdata;
    logic      wvalid;
    logic      wready;
    axi_resp_t bresp;
    logic      bvalid;
    logic      bready;
    reg_addr_t araddr;
    logic      arvalid;
    logic      arready;
    reg_data_t rdata;
    axi_resp_t rresp;
    logic      rvalid;
    logic      rready;

    spi_slave u_spi_slave (
        .clk          (clk),
        .rst_n        (rst_n),
        .sck          (spi_sck),
        .ss_n         (spi_ss_n),
        .mosi         (spi_mosi),
        .miso         (spi_miso),
        .rx_byte      (rx_byte),
        .rx_valid     (rx_valid),
        .frame_active (frame_active),
        .tx_byte      (tx_byte),
        .tx_load      (tx_load)
    );

    spi_cmd_master u_spi_cmd_master (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx_byte      (rx_byte),
        .rx_valid     (rx_valid),
        .frame_active (frame_active),
        .tx_byte      (tx_byte),
        .tx_load      (tx_load),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wvalid       (wvalid),
        .wready       (wready),
        .bresp        (bresp),
        .bvalid       (bvalid),
        .bready       (bready),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rvalid       (rvalid),
        .rready       (rready)
    );

    reg_bank u_reg_bank (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

endmodule

//--- spi_reg_bridge_checker.sv
// Concurrent checks on the parser side of the internal AXI4-Lite link and the byte strobe
// Bound into spi_cmd_master, all checks are off while rst_n is low
`timescale 1ns/1ps

module spi_reg_bridge_checker (
    input logic                clk,
    input logic                rst_n,
    input logic                rx_valid,
    input logic                frame_active,
    input regs_pkg::reg_addr_t awaddr,
    input logic                awvalid,
    input logic                awready,
    input regs_pkg::reg_data_t wdata,
    input logic                wvalid,
    input logic                wready,
    input regs_pkg::reg_addr_t araddr,
    input logic                arvalid,
    input logic                arready
);

    // Number of failed checks so far
    int fail_cnt = 0;

    // A raised write address stays up with the same address until it is taken
    assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else begin
            fail_cnt++;
            $error("awvalid dropped or awaddr changed before awready");
        end

    // Same rule for the write data channel
    assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else begin
            fail_cnt++;
            $error("wvalid dropped or wdata changed before wready");
        end

    // And for the read address channel
    assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            fail_cnt++;
            $error("arvalid dropped or araddr changed before arready");
        end

    // A received byte only exists inside a frame
    assert property (@(posedge clk) disable iff (!rst_n)
        rx_valid |-> frame_active)
        else begin
            fail_cnt++;
            $error("rx_valid pulsed while the frame was inactive");
        end

    // Only one transaction is outstanding, so reads and writes never overlap
    assert property (@(posedge clk) disable iff (!rst_n)
        !(arvalid && awvalid))
        else begin
            fail_cnt++;
            $error("arvalid and awvalid were high together");
        end

endmodule

//--- spi_slave.sv
// Mode 0 SPI slave oversampled by clk, so SCK must stay well below clk / (2 * filter length)
// SCK and select are sampled straight from the pins, their history acts as the synchronizer
`timescale 1ns/1ps

module spi_slave (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               sck,
    input  logic               ss_n,
    input  logic               mosi,
    output logic               miso,
    output spi_pkg::spi_byte_t rx_byte,
    output logic               rx_valid,
    output logic               frame_active,
    input  spi_pkg::spi_byte_t tx_byte,
    input  logic               tx_load
);
    import spi_pkg::*;

    logic [SPI_FILTER_LEN-1:0] sck_hist;
    logic [SPI_FILTER_LEN-1:0] ss_hist;
    logic                      sck_state;
    logic                      sck_rise;
    logic                      sck_fall;
    bit_cnt_t                  bit_cnt;
    spi_byte_t                 rx_shift;
    spi_byte_t                 tx_shift;

    // Sample histories of the raw pins, newest sample in bit 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sck_hist <= '0;
            ss_hist  <= '1;
        end else begin
            sck_hist <= {sck_hist[SPI_FILTER_LEN-2:0], sck};
            ss_hist  <= {ss_hist[SPI_FILTER_LEN-2:0], ss_n};
        end
    end

    // A new SCK level is only taken once the whole history agrees with it
    // Shorter pulses never fill the history and are lost
    assign sck_rise = !sck_state && (&sck_hist);
    assign sck_fall = sck_state && !(|sck_hist);

    // Select is biased towards staying active
    // The frame ends only when every recent sample is high
    assign frame_active = !(&ss_hist);

    // Bit counter, accepted SCK level and the transmit register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sck_state <= 1'b0;
            bit_cnt   <= '0;
            rx_valid  <= 1'b0;
            tx_shift  <= '0;
        end else begin
            rx_valid <= 1'b0;
            if (!frame_active) begin
                // Between frames everything restarts at bit 0 with nothing to send
                sck_state <= 1'b0;
                bit_cnt   <= '0;
                tx_shift  <= '0;
            end else begin
                if (sck_rise) begin
                    sck_state <= 1'b1;
                    bit_cnt   <= bit_cnt + 1'b1;
                    if (bit_cnt == '1) begin
                        // Byte boundary, an unloaded next byte goes out as zero
                        rx_valid <= 1'b1;
                        tx_shift <= '0;
                    end
                end else if (sck_fall) begin
                    sck_state <= 1'b0;
                    // No shift after the last bit, the next byte starts from a load
                    if (bit_cnt != '0) begin
                        tx_shift <= {tx_shift[6:0], 1'b0};
                    end
                end
                // The parser only loads between bytes
                if (tx_load && bit_cnt == '0) begin
                    tx_shift <= tx_byte;
                end
            end
        end
    end

    // MOSI is captured on the accepted rising edge, MSB first
    always_ff @(posedge clk) begin
        if (frame_active && sck_rise) begin
            rx_shift <= {rx_shift[6:0], mosi};
        end
    end

    assign rx_byte = rx_shift;
    assign miso    = frame_active & tx_shift[7];

endmodule

//--- tb_spi_reg_bridge.sv
// Testbench for the SPI to register bridge, a bit-banged mode 0 master against a register model
// SCK runs at 12 clk cycles per half period, well above the 8 sample filter of the slave
`timescale 1ns/1ps

module tb_spi_reg_bridge;
    import spi_pkg::*;
    import regs_pkg::*;

    localparam int SEED      = 2455;
    localparam int HALF      = 12;
    // SCK low time between bytes, long enough for a read result to load
    localparam int GAP       = 20;
    localparam int FRAME_GAP = 16;
    localparam int NUM_REGS  = 1 << $bits(reg_addr_t);
    localparam int N_RANDOM  = 200;
    localparam int N_TRAIL   = 40;
    localparam int N_GLITCH  = 40;
    // Reads of all registers appear in four phases, plus a write per register in one more
    localparam int NUM_FRAMES = 5 * NUM_REGS + N_RANDOM + N_TRAIL + N_GLITCH;
    // Worst case frame is four bytes with a glitch on every bit and a select spike
    localparam int MAX_FRAME_CYCLES = 4 * (8 * (3 * HALF + 8) + HALF + GAP + 8) + FRAME_GAP + 8;
    localparam int WATCHDOG_CYCLES  = NUM_FRAMES * MAX_FRAME_CYCLES + 1000;

    logic clk;
    logic rst_n;
    logic spi_sck;
    logic spi_ss_n;
    logic spi_mosi;
    logic spi_miso;

    reg_data_t model [NUM_REGS];

    spi_reg_bridge UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .spi_sck  (spi_sck),
        .spi_ss_n (spi_ss_n),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

    // Protocol checks on the parser's AXI4-Lite side
    bind spi_cmd_master spi_reg_bridge_checker u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx_valid     (rx_valid),
        .frame_active (frame_active),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wvalid       (wvalid),
        .wready       (wready),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic wait_clks(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic check_byte(input string what, input spi_byte_t expected,
                              input spi_byte_t actual);
        assert (actual == expected) else begin
            $display("error: time %0t ns, spi_miso read data (%s), expected 0x%02h, actual 0x%02h",
                     $time, what, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "Read data mismatch");
        end
    endtask

    // Shifts one byte MSB first and returns what came back on MISO
    // Called on a clk edge with SCK low, returns on a clk edge with SCK low again
    task automatic spi_xfer(input spi_byte_t tx, input int glitch_len, output spi_byte_t rx);
        rx = '0;
        for (int b = 7; b >= 0; b--) begin
            spi_mosi <= tx[b];
            wait_clks(HALF);
            if (glitch_len > 0) begin
                // Short high pulse that the filter must swallow
                spi_sck <= 1'b1;
                wait_clks(glitch_len);
                spi_sck <= 1'b0;
                wait_clks(HALF);
            end
            // MISO has been stable since the accepted falling edge
            rx[b] = spi_miso;
            spi_sck <= 1'b1;
            wait_clks(HALF);
            spi_sck <= 1'b0;
        end
        wait_clks(HALF);
    endtask

    // One frame: command byte, then n_bytes - 1 more bytes
    // A single byte write frame is an aborted write and must not change the registers
    task automatic run_frame(input logic is_write, input reg_addr_t addr, input reg_data_t data,
                             input int n_bytes, input int glitch_len, input int spike_len);
        spi_byte_t cmd;
        spi_byte_t tx;
        spi_byte_t rx;
        // Bits 6:3 of the command carry no meaning, so they get random values
        cmd    = spi_byte_t'($urandom);
        cmd[7] = is_write;
        cmd[2:0] = addr;
        @(posedge clk);
        spi_ss_n <= 1'b0;
        wait_clks(HALF);
        for (int i = 0; i < n_bytes; i++) begin
            if (i == 0) begin
                tx = cmd;
            end else if (i == 1 && is_write) begin
                tx = data;
            end else begin
                tx = spi_byte_t'($urandom);
            end
            spi_xfer(tx, glitch_len, rx);
            if (i == 0) begin
                check_byte("command byte", 8'h00, rx);
            end else if (i == 1 && !is_write) begin
                check_byte("register read", model[addr], rx);
            end else if (i >= 2) begin
                check_byte("trailing byte", 8'h00, rx);
            end
            if (i == 0 && spike_len > 0) begin
                // Select spike inside the frame, too short to end it
                spi_ss_n <= 1'b1;
                wait_clks(spike_len);
                spi_ss_n <= 1'b0;
            end
            wait_clks(GAP);
        end
        spi_ss_n <= 1'b1;
        wait_clks(FRAME_GAP);
        if (is_write && n_bytes >= 2) begin
            model[addr] = data;
        end
    endtask

    // Reads every register back against the model
    task automatic read_all_regs();
        for (int a = 0; a < NUM_REGS; a++) begin
            run_frame(1'b0, reg_addr_t'(a), 8'h00, 2, 0, 0);
        end
    endtask

    // Watchdog sized from the number of frames and the longest frame
    initial begin
        wait_clks(WATCHDOG_CYCLES);
        $display("Timeout: the frames did not finish within %0d clk cycles", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        reg_addr_t addr;
        reg_data_t data;
        logic      is_write;
        int        n_bytes;
        rst_n    = 1'b0;
        spi_sck  = 1'b0;
        spi_ss_n = 1'b1;
        spi_mosi = 1'b0;
        void'($urandom(SEED));
        for (int a = 0; a < NUM_REGS; a++) begin
            model[a] = '0;
        end
        wait_clks(4);
        rst_n <= 1'b1;
        wait_clks(4);

        // Registers come out of reset cleared
        read_all_regs();

        // Directed write then read back on every address
        for (int a = 0; a < NUM_REGS; a++) begin
            data = reg_data_t'($urandom);
            run_frame(1'b1, reg_addr_t'(a), data, 2, 0, 0);
            run_frame(1'b0, reg_addr_t'(a), 8'h00, 2, 0, 0);
        end

        // Random mix of reads and writes
        for (int n = 0; n < N_RANDOM; n++) begin
            is_write = ($urandom_range(1, 0) == 1);
            addr     = reg_addr_t'($urandom_range(NUM_REGS - 1, 0));
            data     = reg_data_t'($urandom);
            run_frame(is_write, addr, data, 2, 0, 0);
        end

        // Aborted writes and frames with trailing bytes
        for (int n = 0; n < N_TRAIL; n++) begin
            addr = reg_addr_t'($urandom_range(NUM_REGS - 1, 0));
            data = reg_data_t'($urandom);
            if ($urandom_range(2, 0) == 0) begin
                run_frame(1'b1, addr, data, 1, 0, 0);
            end else begin
                is_write = ($urandom_range(1, 0) == 1);
                n_bytes  = $urandom_range(4, 3);
                run_frame(is_write, addr, data, n_bytes, 0, 0);
            end
        end
        read_all_regs();

        // SCK glitches and select spikes shorter than the filter
        for (int n = 0; n < N_GLITCH; n++) begin
            is_write = ($urandom_range(1, 0) == 1);
            addr     = reg_addr_t'($urandom_range(NUM_REGS - 1, 0));
            data     = reg_data_t'($urandom);
            run_frame(is_write, addr, data, 2, $urandom_range(6, 1), $urandom_range(6, 1));
        end
        read_all_regs();

        // Failures of the bound protocol checks are counted inside the checker
        if (UUT.u_spi_cmd_master.u_checker.fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("TESTBENCH FAILED");
            $fatal(1, "Bound protocol checks failed");
        end
    end

endmodule
